/* common/zip_dbg_pkg.sv */
/*
 * Shared types and constants for the debug controller.
 * The debug bus is fixed at 32 data bits and an 8 bit byte address.
 * All control and status bits sit in byte lane 0.
 */
`default_nettype none

package zip_dbg_pkg;

	////////////////////
	// Data types
	////////////////////

	// One debug bus word
	typedef logic [31:0] dbg_word_t;
	// Byte strobes for one word
	typedef logic [3:0] dbg_strb_t;
	// Word address, bit 5 selects the space
	typedef logic [5:0] dbg_waddr_t;
	// Core register file index
	typedef logic [4:0] reg_index_t;
	// Core condition flags, bit 0 sleep and bit 1 user mode
	typedef logic [2:0] dbg_cc_t;

	////////////////////
	// Address decode
	////////////////////

	// Space select values
	localparam logic DBG_ADDR_CTRL = 1'b0;
	localparam logic DBG_ADDR_CPU = 1'b1;

	// Byte address bits below the word address
	localparam int DBG_LSB = 2;
	localparam int DBG_BYTE_ADDR_W = $bits(dbg_waddr_t) + DBG_LSB;

	////////////////////
	// Control register
	////////////////////

	localparam int HALT_BIT = 0;
	// Read only, core has stopped
	localparam int HALTED_BIT = 1;
	localparam int STEP_BIT = 2;
	localparam int RESET_BIT = 3;
	localparam int CLEAR_CACHE_BIT = 4;
	localparam int CATCH_BIT = 5;

	// Status fields, read only
	localparam int STAT_SLEEP_BIT = 8;
	localparam int STAT_GIE_BIT = 9;
	localparam int STAT_IRQ_BIT = 10;
	localparam int STAT_BREAK_BIT = 11;

	// Only response this slave ever gives
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

/* dv/tb_zip_dbg.sv */
/*
 * Testbench for zip_dbg_top with a 32-entry core model.
 * Stops at the first error. Core stall is halt inverted, one cycle late.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_zip_dbg;

	localparam int RESET_DURATION = 10;
	localparam int TIMEOUT = 64;
	// AXI OKAY response code
	localparam logic [1:0] RESP_OKAY = 2'b00;

	// Table operations
	localparam logic [2:0] OP_WRITE = 3'd0;
	localparam logic [2:0] OP_READ = 3'd1;
	localparam logic [2:0] OP_BREAK = 3'd2;
	localparam logic [2:0] OP_RESET_CHK = 3'd3;
	localparam logic [2:0] OP_DROPS = 3'd4;
	localparam logic [2:0] OP_CLEARS = 3'd5;
	localparam logic [2:0] OP_FLAGS = 3'd6;

	typedef struct packed {
		logic [2:0] op;
		logic [7:0] addr;
		logic [31:0] data;
		logic [3:0] strb;
		logic [31:0] exp_val;
	} step_t;

	logic S_AXI_ACLK = 1'b0;
	logic S_AXI_ARESETN;
	logic S_DBG_AWVALID, S_DBG_AWREADY, S_DBG_WVALID, S_DBG_WREADY;
	logic [7:0] S_DBG_AWADDR, S_DBG_ARADDR;
	logic [31:0] S_DBG_WDATA, S_DBG_RDATA;
	logic [3:0] S_DBG_WSTRB;
	logic S_DBG_BVALID, S_DBG_BREADY, S_DBG_ARVALID, S_DBG_ARREADY;
	logic S_DBG_RVALID, S_DBG_RREADY;
	logic [1:0] S_DBG_BRESP, S_DBG_RRESP;
	logic o_cpu_reset, o_cpu_halt, o_cpu_clear_cache, o_cpu_dbg_we;
	logic [4:0] o_cpu_dbg_wreg, o_cpu_dbg_rreg;
	logic [31:0] o_cpu_dbg_wdata, i_cpu_dbg_data;
	logic i_cpu_dbg_stall, i_cpu_break, i_interrupt, i_cpu_reset;
	logic [2:0] i_cpu_dbg_cc;

	// Core model state
	logic [31:0] core_regs [32];
	logic core_stall;
	// Falling edges of o_cpu_halt seen so far
	int halt_drops = 0;
	logic halt_prev = 1'b0;
	// Rising edges of o_cpu_clear_cache seen so far
	int clear_pulses = 0;
	logic clear_prev = 1'b0;
	step_t steps[$];

	zip_dbg_top #(
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(1'b1)
	) zip_dbg_top_inst (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_DBG_AWVALID(S_DBG_AWVALID), .S_DBG_AWREADY(S_DBG_AWREADY),
		.S_DBG_AWADDR(S_DBG_AWADDR), .S_DBG_WVALID(S_DBG_WVALID),
		.S_DBG_WREADY(S_DBG_WREADY), .S_DBG_WDATA(S_DBG_WDATA), .S_DBG_WSTRB(S_DBG_WSTRB),
		.S_DBG_BVALID(S_DBG_BVALID), .S_DBG_BREADY(S_DBG_BREADY), .S_DBG_BRESP(S_DBG_BRESP),
		.S_DBG_ARVALID(S_DBG_ARVALID), .S_DBG_ARREADY(S_DBG_ARREADY),
		.S_DBG_ARADDR(S_DBG_ARADDR), .S_DBG_RVALID(S_DBG_RVALID),
		.S_DBG_RREADY(S_DBG_RREADY), .S_DBG_RDATA(S_DBG_RDATA), .S_DBG_RRESP(S_DBG_RRESP),
		.o_cpu_reset(o_cpu_reset), .o_cpu_halt(o_cpu_halt),
		.o_cpu_clear_cache(o_cpu_clear_cache), .o_cpu_dbg_we(o_cpu_dbg_we),
		.o_cpu_dbg_wreg(o_cpu_dbg_wreg), .o_cpu_dbg_wdata(o_cpu_dbg_wdata),
		.o_cpu_dbg_rreg(o_cpu_dbg_rreg), .i_cpu_dbg_stall(i_cpu_dbg_stall),
		.i_cpu_dbg_data(i_cpu_dbg_data), .i_cpu_dbg_cc(i_cpu_dbg_cc),
		.i_cpu_break(i_cpu_break), .i_interrupt(i_interrupt), .i_cpu_reset(i_cpu_reset)
	);

	bind zip_dbg_top zip_dbg_checker #(
		.RESET_DURATION(RESET_DURATION)
	) protocol_checker (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_bvalid(S_DBG_BVALID), .i_bready(S_DBG_BREADY), .i_bresp(S_DBG_BRESP),
		.i_rvalid(S_DBG_RVALID), .i_rready(S_DBG_RREADY), .i_rdata(S_DBG_RDATA),
		.i_rresp(S_DBG_RRESP), .i_cpu_dbg_we(o_cpu_dbg_we), .i_cpu_halt(o_cpu_halt),
		.i_core_reset(o_cpu_reset)
	);

	always #4 S_AXI_ACLK = ~S_AXI_ACLK;

	////////////////////
	// Core model
	////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		core_stall <= !o_cpu_halt;
		if (o_cpu_reset)
			for (int i = 0; i < 32; i++)
				core_regs[i] <= '0;
		else if (o_cpu_dbg_we && !core_stall)
			core_regs[o_cpu_dbg_wreg] <= o_cpu_dbg_wdata;
	end

	assign i_cpu_dbg_stall = core_stall;
	assign i_cpu_dbg_data = core_regs[o_cpu_dbg_rreg];

	// Halt and clear-cache pulses are a full cycle long, so the falling edge sees them
	always @(negedge S_AXI_ACLK)
	begin
		halt_prev <= o_cpu_halt;
		clear_prev <= o_cpu_clear_cache;
		if (halt_prev && !o_cpu_halt)
			halt_drops <= halt_drops + 1;
		if (!clear_prev && o_cpu_clear_cache)
			clear_pulses <= clear_pulses + 1;
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [31:0] got,
		input logic [31:0] exp_val);
		if (got !== exp_val)
			stop_with_error($sformatf("FAILED %s: got 0x%08h, expected 0x%08h",
				name, got, exp_val));
	endtask

	task automatic add_step(input logic [2:0] op, input logic [7:0] addr,
		input logic [31:0] data, input logic [3:0] strb, input logic [31:0] exp_val);
		steps.push_back('{op, addr, data, strb, exp_val});
	endtask

	// AW and W together, then one B with a random BREADY delay
	task automatic write_bus(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int unsigned waited;
		int unsigned delay;
		bit aw_done;
		bit w_done;
		@(negedge S_AXI_ACLK);
		S_DBG_AWVALID = 1'b1;
		S_DBG_AWADDR = addr;
		S_DBG_WVALID = 1'b1;
		S_DBG_WDATA = data;
		S_DBG_WSTRB = strb;
		aw_done = 1'b0;
		w_done = 1'b0;
		waited = 0;
		while (!(aw_done && w_done))
		begin
			if (waited > TIMEOUT)
				stop_with_error("Timed out waiting for the write address and data to be taken");
			// Ready only moves on the rising edge, which completes the handshake
			aw_done = aw_done || (S_DBG_AWVALID && S_DBG_AWREADY);
			w_done = w_done || (S_DBG_WVALID && S_DBG_WREADY);
			@(negedge S_AXI_ACLK);
			waited++;
			if (aw_done)
				S_DBG_AWVALID = 1'b0;
			if (w_done)
				S_DBG_WVALID = 1'b0;
		end
		waited = 0;
		while (!S_DBG_BVALID)
		begin
			if (waited > TIMEOUT)
				stop_with_error("Timed out waiting for a write response");
			@(negedge S_AXI_ACLK);
			waited++;
		end
		delay = $urandom % 4;
		repeat (delay) @(negedge S_AXI_ACLK);
		compare("S_DBG_BRESP", 32'(S_DBG_BRESP), 32'(RESP_OKAY));
		S_DBG_BREADY = 1'b1;
		@(negedge S_AXI_ACLK);
		S_DBG_BREADY = 1'b0;
		// Exactly one response per write
		compare("S_DBG_BVALID", 32'(S_DBG_BVALID), 32'd0);
	endtask

	task automatic read_bus(input logic [7:0] addr, input logic [31:0] exp_val);
		int unsigned waited;
		int unsigned delay;
		logic [31:0] data;
		@(negedge S_AXI_ACLK);
		S_DBG_ARVALID = 1'b1;
		S_DBG_ARADDR = addr;
		waited = 0;
		while (!S_DBG_ARREADY)
		begin
			if (waited > TIMEOUT)
				stop_with_error("Timed out waiting for the read address to be taken");
			@(negedge S_AXI_ACLK);
			waited++;
		end
		// Taken on the coming rising edge
		@(negedge S_AXI_ACLK);
		S_DBG_ARVALID = 1'b0;
		waited = 0;
		while (!S_DBG_RVALID)
		begin
			if (waited > TIMEOUT)
				stop_with_error("Timed out waiting for read data");
			@(negedge S_AXI_ACLK);
			waited++;
		end
		delay = $urandom % 4;
		repeat (delay) @(negedge S_AXI_ACLK);
		compare("S_DBG_RRESP", 32'(S_DBG_RRESP), 32'(RESP_OKAY));
		data = S_DBG_RDATA;
		S_DBG_RREADY = 1'b1;
		@(negedge S_AXI_ACLK);
		S_DBG_RREADY = 0;
		compare("S_DBG_RVALID", 32'(S_DBG_RVALID), 32'd0);
		compare($sformatf("S_DBG_RDATA at 0x%02h", addr), data, exp_val);
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial
	begin
		int unsigned waited;
		void'($urandom(32'h9b7a_9bc4));
		S_AXI_ARESETN = 1'b0;
		S_DBG_AWVALID = 1'b0;
		S_DBG_AWADDR = '0;
		S_DBG_WVALID = 1'b0;
		S_DBG_WDATA = '0;
		S_DBG_WSTRB = '0;
		S_DBG_BREADY = 1'b0;
		S_DBG_ARVALID = 1'b0;
		S_DBG_ARADDR = '0;
		S_DBG_RREADY = 1'b0;
		i_cpu_dbg_cc = '0;
		i_cpu_break = 1'b0;
		i_interrupt = 1'b0;
		i_cpu_reset = 1'b0;
		repeat (3) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;

		// Reset hold has to run out
		waited = 0;
		while (o_cpu_reset !== 1'b0)
		begin
			if (waited > TIMEOUT)
				stop_with_error("Core reset never dropped after the reset hold");
			@(negedge S_AXI_ACLK);
			waited++;
		end

		// Status after reset is halt, halted, catch
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0023);
		add_step(OP_RESET_CHK, 8'h00, 32'h0, 4'h0, 32'h0);
		add_step(OP_CLEARS, 8'h00, 32'h0, 4'h0, 32'd0);
		// Release, halt, catch off, catch on, empty strobes
		add_step(OP_WRITE, 8'h00, 32'h0000_0020, 4'hf, 32'h0);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0020);
		add_step(OP_WRITE, 8'h00, 32'h0000_0021, 4'hf, 32'h0);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0023);
		add_step(OP_WRITE, 8'h00, 32'h0000_0001, 4'hf, 32'h0);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0003);
		add_step(OP_WRITE, 8'h00, 32'h0000_0021, 4'hf, 32'h0);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0023);
		add_step(OP_WRITE, 8'h00, 32'h0000_0000, 4'h0, 32'h0);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0023);
		// Core registers and one partial write that must be dropped
		add_step(OP_WRITE, 8'h84, 32'h1234_5678, 4'hf, 32'h0);
		add_step(OP_WRITE, 8'hbc, 32'hcafe_f00d, 4'hf, 32'h0);
		add_step(OP_WRITE, 8'hfc, 32'ha5a5_5a5a, 4'hf, 32'h0);
		add_step(OP_READ, 8'h84, 32'h0, 4'h0, 32'h1234_5678);
		add_step(OP_READ, 8'hbc, 32'h0, 4'h0, 32'hcafe_f00d);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0023);
		add_step(OP_WRITE, 8'h84, 32'hffff_ffff, 4'h3, 32'h0);
		add_step(OP_READ, 8'h84, 32'h0, 4'h0, 32'h1234_5678);
		add_step(OP_READ, 8'hfc, 32'h0, 4'h0, 32'ha5a5_5a5a);
		// The release gave one drop and the step adds another
		add_step(OP_DROPS, 8'h00, 32'h0, 4'h0, 32'd1);
		add_step(OP_WRITE, 8'h00, 32'h0000_0025, 4'hf, 32'h0);
		add_step(OP_DROPS, 8'h00, 32'h0, 4'h0, 32'd2);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0023);
		// Break with catch set halts a running core
		add_step(OP_WRITE, 8'h00, 32'h0000_0020, 4'hf, 32'h0);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0020);
		add_step(OP_BREAK, 8'h00, 32'h1, 4'h0, 32'h0);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0823);
		add_step(OP_BREAK, 8'h00, 32'h0, 4'h0, 32'h0);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0023);
		// Break with catch clear resets the core and its registers
		add_step(OP_WRITE, 8'h00, 32'h0000_0001, 4'hf, 32'h0);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0003);
		add_step(OP_BREAK, 8'h00, 32'h1, 4'h0, 32'h0);
		add_step(OP_RESET_CHK, 8'h00, 32'h0, 4'h0, 32'h1);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_080b);
		add_step(OP_BREAK, 8'h00, 32'h0, 4'h0, 32'h0);
		add_step(OP_RESET_CHK, 8'h00, 32'h0, 4'h0, 32'h0);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0003);
		add_step(OP_READ, 8'h84, 32'h0, 4'h0, 32'h0);
		add_step(OP_READ, 8'hfc, 32'h0, 4'h0, 32'h0);
		// Core write on a running core forces halt and waits out the stall
		add_step(OP_WRITE, 8'h00, 32'h0000_0020, 4'hf, 32'h0);
		add_step(OP_WRITE, 8'h88, 32'h0bad_beef, 4'hf, 32'h0);
		add_step(OP_READ, 8'h88, 32'h0, 4'h0, 32'h0bad_beef);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0023);
		// Clear cache together with halt gives one pulse
		add_step(OP_WRITE, 8'h00, 32'h0000_0031, 4'hf, 32'h0);
		add_step(OP_CLEARS, 8'h00, 32'h0, 4'h0, 32'd1);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0023);
		// Sleep, user mode and interrupt flags with cc bit 2 ignored
		add_step(OP_FLAGS, 8'h00, 32'hf, 4'h0, 32'h0);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0723);
		add_step(OP_FLAGS, 8'h00, 32'h0, 4'h0, 32'h0);
		add_step(OP_READ, 8'h00, 32'h0, 4'h0, 32'h0000_0023);

		foreach (steps[i])
		begin
			case (steps[i].op)
				OP_WRITE: write_bus(steps[i].addr, steps[i].data, steps[i].strb);
				OP_READ: read_bus(steps[i].addr, steps[i].exp_val);
				OP_BREAK:
				begin
					@(negedge S_AXI_ACLK);
					i_cpu_break = steps[i].data[0];
					// Halt or reset follows next cycle and core stall one later
					repeat (3) @(negedge S_AXI_ACLK);
				end
				OP_FLAGS:
				begin
					@(negedge S_AXI_ACLK);
					i_cpu_dbg_cc = steps[i].data[2:0];
					i_interrupt = steps[i].data[3];
				end
				OP_RESET_CHK: compare("o_cpu_reset", 32'(o_cpu_reset), steps[i].exp_val);
				OP_DROPS: compare("o_cpu_halt drop count", 32'(halt_drops), steps[i].exp_val);
				OP_CLEARS:
					compare("o_cpu_clear_cache pulse count", 32'(clear_pulses),
						steps[i].exp_val);
				default: stop_with_error("Unknown operation in the stimulus table");
			endcase
		end

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/zip_dbg_checker.sv */
/*
 * Protocol and control assertions, bound into zip_dbg_top.
 * The hold count restarts only on S_AXI_ARESETN, not on i_cpu_reset.
 */
`timescale 1ns/1ps
`default_nettype none

module zip_dbg_checker #(
	parameter int RESET_DURATION = 10
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire i_bvalid,
	input wire i_bready,
	input wire [1:0] i_bresp,
	input wire i_rvalid,
	input wire i_rready,
	input wire [31:0] i_rdata,
	input wire [1:0] i_rresp,
	input wire i_cpu_dbg_we,
	input wire i_cpu_halt,
	input wire i_core_reset
);

	// Cycles since reset release, saturating
	int unsigned hold_count;

	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		hold_count <= 0;
	else if (hold_count < RESET_DURATION)
		hold_count <= hold_count + 1;

	// B held with its response until taken
	b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(i_bvalid && !i_bready) |=> (i_bvalid && $stable(i_bresp)))
		else $error("B channel dropped or changed before BREADY");

	// R held with data until taken
	r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(i_rvalid && !i_rready) |=> (i_rvalid && $stable(i_rdata) && $stable(i_rresp)))
		else $error("R channel dropped or changed before RREADY");

	// Register writes only reach a halted core
	we_halted: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_cpu_dbg_we |-> i_cpu_halt)
		else $error("Core register write while the core is not halted");

	reset_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(hold_count < RESET_DURATION) |-> i_core_reset)
		else $error("Core reset dropped inside the reset hold");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the debug controller testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_zip_dbg -f verilog.f -o Vtb_zip_dbg
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_zip_dbg
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

/* source/cpu_command_ctrl.sv */
/*
 * Halt, reset, step, clear-cache and catch flags plus the core write stage.
 * RESET_DURATION must be 1 or more; i_cpu_reset_in restarts the hold.
 * Release and step act only when the core is idle.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_command_ctrl #(
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED = 1'b1
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Accepted control write
	input wire i_cmd_write,
	input wire zip_dbg_pkg::dbg_word_t i_cmd_data,
	input wire zip_dbg_pkg::dbg_strb_t i_cmd_strb,
	// Accepted full-word core write
	input wire i_cpu_write,
	input wire zip_dbg_pkg::reg_index_t i_cpu_wreg,
	input wire zip_dbg_pkg::dbg_word_t i_cpu_wdata,
	// Core inputs
	input wire i_cpu_reset_in,
	input wire i_cpu_dbg_stall,
	input wire i_cpu_break,
	input wire zip_dbg_pkg::dbg_cc_t i_cpu_dbg_cc,
	input wire i_interrupt,
	// Core debug port
	output logic o_cpu_reset,
	output logic o_cpu_halt,
	output logic o_cpu_clear_cache,
	output logic o_cpu_dbg_we,
	output zip_dbg_pkg::reg_index_t o_cpu_dbg_wreg,
	output zip_dbg_pkg::dbg_word_t o_cpu_dbg_wdata,
	output wire o_write_stall,
	output zip_dbg_pkg::dbg_word_t o_status
);

	import zip_dbg_pkg::*;

	localparam int RC_W = $clog2(RESET_DURATION + 1);

	logic [RC_W-1:0] reset_counter;
	logic cmd_step;
	logic dbg_catch;
	wire reset_hold;
	wire halt_request, release_request, step_request;
	wire reset_request, clear_cache_request;
	wire core_idle;

	// Command decode, all bits live in byte lane 0
	assign halt_request = i_cmd_write && i_cmd_strb[HALT_BIT/8] && i_cmd_data[HALT_BIT];
	assign release_request = i_cmd_write && i_cmd_strb[HALT_BIT/8]
		&& !i_cmd_data[HALT_BIT];
	assign step_request = i_cmd_write && i_cmd_strb[STEP_BIT/8] && i_cmd_data[STEP_BIT];
	assign reset_request = i_cmd_write && i_cmd_strb[RESET_BIT/8] && i_cmd_data[RESET_BIT];
	assign clear_cache_request = i_cmd_write && i_cmd_strb[CLEAR_CACHE_BIT/8]
		&& i_cmd_data[CLEAR_CACHE_BIT];

	// No pending register write and core stopped
	assign core_idle = !o_cpu_dbg_we && !i_cpu_dbg_stall;

	////////////////////
	// Reset hold
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN || i_cpu_reset_in)
		reset_counter <= RC_W'(RESET_DURATION);
	else if (reset_hold)
		reset_counter <= reset_counter - 1'b1;

	assign reset_hold = (reset_counter != '0);

	// Hold, break without catch, or a one-cycle request
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN || i_cpu_reset_in)
		o_cpu_reset <= 1'b1;
	else if (reset_hold || (i_cpu_break && !dbg_catch))
		o_cpu_reset <= 1'b1;
	else
		o_cpu_reset <= reset_request;

	////////////////////
	// Halt and friends
	////////////////////

	// Later statements win, so every halt source beats a release
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		o_cpu_halt <= START_HALTED;
	else if (i_cpu_reset_in && !i_cpu_write && !o_write_stall)
		o_cpu_halt <= START_HALTED;
	else if (o_cpu_reset && START_HALTED)
		o_cpu_halt <= START_HALTED;
	else
	begin
		if (core_idle && (release_request || step_request))
			o_cpu_halt <= 1'b0;
		// Fault caught by the debugger
		if (i_cpu_break && dbg_catch)
			o_cpu_halt <= 1'b1;
		// Plain halt, unless stepping
		if (halt_request && !step_request)
			o_cpu_halt <= 1'b1;
		if (i_cpu_write || cmd_step)
			o_cpu_halt <= 1'b1;
		if (o_cpu_clear_cache || clear_cache_request)
			o_cpu_halt <= 1'b1;
	end

	// Step lasts until the core starts moving
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN || i_cpu_reset_in)
		cmd_step <= 1'b0;
	else if (step_request)
		cmd_step <= 1'b1;
	else if (!i_cpu_dbg_stall)
		cmd_step <= 1'b0;

	// Needs halt in the same write, clears once stopped
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN || o_cpu_reset)
		o_cpu_clear_cache <= 1'b0;
	else if (clear_cache_request && halt_request)
		o_cpu_clear_cache <= 1'b1;
	else if (o_cpu_halt && !i_cpu_dbg_stall)
		o_cpu_clear_cache <= 1'b0;

	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		dbg_catch <= START_HALTED;
	else if (i_cmd_write && i_cmd_strb[CATCH_BIT/8])
		dbg_catch <= i_cmd_data[CATCH_BIT];

	////////////////////
	// Core write stage
	////////////////////

	// Frozen while the core is still busy
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		o_cpu_dbg_we <= 1'b0;
	else if (!o_write_stall)
		o_cpu_dbg_we <= i_cpu_write;

	always_ff @(posedge S_AXI_ACLK)
	if (!o_write_stall)
	begin
		o_cpu_dbg_wreg <= i_cpu_wreg;
		o_cpu_dbg_wdata <= i_cpu_wdata;
	end

	assign o_write_stall = o_cpu_dbg_we && i_cpu_dbg_stall;

	// Status word, unlisted bits read zero
	always_comb
	begin
		o_status = '0;
		o_status[HALT_BIT] = o_cpu_halt;
		o_status[HALTED_BIT] = !i_cpu_dbg_stall;
		o_status[RESET_BIT] = o_cpu_reset;
		o_status[CLEAR_CACHE_BIT] = o_cpu_clear_cache;
		o_status[CATCH_BIT] = dbg_catch;
		o_status[STAT_SLEEP_BIT] = i_cpu_dbg_cc[0];
		o_status[STAT_GIE_BIT] = i_cpu_dbg_cc[1];
		o_status[STAT_IRQ_BIT] = i_interrupt;
		o_status[STAT_BREAK_BIT] = i_cpu_break;
	end

endmodule

`default_nettype wire

/* source/dbg_request_decode.sv */
/*
 * Joins AW and W, applies the acceptance and strobe rules and splits
 * requests by address space. Purely combinational.
 * Core writes need all four strobes, anything less is accepted and dropped.
 */
`timescale 1ns/1ps
`default_nettype none

module dbg_request_decode (
	// Write address and data from the skid buffers
	input wire i_aw_valid,
	input wire zip_dbg_pkg::dbg_waddr_t i_aw_addr,
	input wire i_w_valid,
	input wire zip_dbg_pkg::dbg_word_t i_w_data,
	input wire zip_dbg_pkg::dbg_strb_t i_w_strb,
	// Read address from its skid buffer
	input wire i_ar_valid,
	input wire zip_dbg_pkg::dbg_waddr_t i_ar_addr,
	// Back-pressure
	input wire i_write_stall,
	input wire i_b_busy,
	input wire i_r_busy,
	// Accept pulses, also the skid buffer readies
	output wire o_write_ready,
	output wire o_read_ready,
	// Control space write
	output wire o_cmd_write,
	output zip_dbg_pkg::dbg_word_t o_cmd_data,
	output zip_dbg_pkg::dbg_strb_t o_cmd_strb,
	// Core register write
	output wire o_cpu_write,
	output zip_dbg_pkg::reg_index_t o_cpu_wreg,
	output zip_dbg_pkg::dbg_word_t o_cpu_wdata,
	// Read space select and index
	output wire o_read_cpu,
	output zip_dbg_pkg::reg_index_t o_rreg
);

	import zip_dbg_pkg::*;

	// Top word address bit picks the space
	localparam int SPACE_BIT = $bits(dbg_waddr_t) - 1;
	localparam int IDX_W = $bits(reg_index_t);

	wire aw_ctrl_space;
	wire aw_cpu_space;
	wire strb_none;
	wire strb_full;

	assign aw_ctrl_space = (i_aw_addr[SPACE_BIT] == DBG_ADDR_CTRL);
	assign aw_cpu_space = (i_aw_addr[SPACE_BIT] == DBG_ADDR_CPU);
	assign strb_none = (i_w_strb == '0);
	assign strb_full = &i_w_strb;

	////////////////////
	// Write path
	////////////////////

	// Both halves present and B free or draining
	// Pending core write only blocks writes that could reach the core
	assign o_write_ready = i_aw_valid && i_w_valid && !i_b_busy
		&& (strb_none || aw_ctrl_space || !i_write_stall);

	// Control writes, per-byte enables handled downstream
	assign o_cmd_write = o_write_ready && aw_ctrl_space;
	assign o_cmd_data = i_w_data;
	assign o_cmd_strb = i_w_strb;

	// Full-word writes only reach the core
	assign o_cpu_write = o_write_ready && aw_cpu_space && strb_full;
	assign o_cpu_wreg = i_aw_addr[IDX_W-1:0];
	assign o_cpu_wdata = i_w_data;

	////////////////////
	// Read path
	////////////////////

	// Busy covers a full R and a core read in flight
	assign o_read_ready = i_ar_valid && !i_r_busy;
	assign o_read_cpu = (i_ar_addr[SPACE_BIT] == DBG_ADDR_CPU);

	// Index goes to the core in the accept cycle
	assign o_rreg = i_ar_addr[IDX_W-1:0];

endmodule

`default_nettype wire

/* source/dbg_response.sv */
/*
 * B and R channel registers. Responses are always OKAY.
 * Control reads return one cycle after accept, core reads two.
 */
`timescale 1ns/1ps
`default_nettype none

module dbg_response (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Accept pulses from the decoder
	input wire i_write_accept,
	input wire i_read_accept,
	input wire i_read_cpu,
	// Read data sources
	input wire zip_dbg_pkg::dbg_word_t i_status,
	input wire zip_dbg_pkg::dbg_word_t i_cpu_dbg_data,
	// Write response
	output logic S_DBG_BVALID,
	input wire S_DBG_BREADY,
	output wire [1:0] S_DBG_BRESP,
	// Read response
	output logic S_DBG_RVALID,
	input wire S_DBG_RREADY,
	output zip_dbg_pkg::dbg_word_t S_DBG_RDATA,
	output wire [1:0] S_DBG_RRESP,
	// Back-pressure to the decoder
	output wire o_b_busy,
	output wire o_r_busy
);

	import zip_dbg_pkg::*;

	// Core read waiting for its data
	logic read_pending;

	////////////////////
	// Write response
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		S_DBG_BVALID <= 1'b0;
	else if (i_write_accept)
		S_DBG_BVALID <= 1'b1;
	else if (S_DBG_BREADY)
		S_DBG_BVALID <= 1'b0;

	assign S_DBG_BRESP = AXI_RESP_OKAY;
	assign o_b_busy = S_DBG_BVALID && !S_DBG_BREADY;

	////////////////////
	// Read response
	////////////////////

	// One cycle for the core to answer
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		read_pending <= 1'b0;
	else
		read_pending <= i_read_accept && i_read_cpu;

	// Accept needs R free, so a pending read always finds it open
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		S_DBG_RVALID <= 1'b0;
	else if (!S_DBG_RVALID || S_DBG_RREADY)
		S_DBG_RVALID <= (i_read_accept && !i_read_cpu) || read_pending;

	// Data held with valid until taken
	always_ff @(posedge S_AXI_ACLK)
	if (!S_DBG_RVALID || S_DBG_RREADY)
		S_DBG_RDATA <= read_pending ? i_cpu_dbg_data : i_status;

	assign S_DBG_RRESP = AXI_RESP_OKAY;

	// Includes the core read still in flight
	assign o_r_busy = read_pending || (S_DBG_RVALID && !S_DBG_RREADY);

endmodule

`default_nettype wire

/* source/dbg_skid_buffer.sv */
/*
 * One-entry skid buffer, output taken straight from the input when empty.
 * o_ready is registered, so the upstream path never sees i_ready.
 */
`timescale 1ns/1ps
`default_nettype none

module dbg_skid_buffer #(
	parameter int DW = 8
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Upstream side
	input wire i_valid,
	output wire o_ready,
	input wire [DW-1:0] i_data,
	// Downstream side
	output wire o_valid,
	input wire i_ready,
	output wire [DW-1:0] o_data
);

	// Held beat
	logic r_valid;
	logic [DW-1:0] r_data;

	// Capture when a beat arrives and the consumer stalls
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		r_valid <= 1'b0;
	else if (i_valid && o_ready && !i_ready)
		r_valid <= 1'b1;
	else if (i_ready)
		r_valid <= 1'b0;

	// Payload follows the input while the buffer is empty
	always_ff @(posedge S_AXI_ACLK)
	if (o_ready)
		r_data <= i_data;

	// Full buffer blocks the upstream
	assign o_ready = !r_valid;

	// Held beat goes first
	assign o_valid = i_valid || r_valid;
	assign o_data = r_valid ? r_data : i_data;

endmodule

`default_nettype wire

/* source/zip_dbg_top.sv */
/*
 * Debug controller for the CPU core, AXI4-Lite slave with 32 data bits.
 * Byte address bit 7 selects control (0) or the register file (1).
 * PROT is not supported; address bits 1:0 are ignored.
 */
`timescale 1ns/1ps
`default_nettype none

module zip_dbg_top #(
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED = 1'b1
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// AXI4-Lite debug slave
	input wire S_DBG_AWVALID,
	output wire S_DBG_AWREADY,
	input wire [zip_dbg_pkg::DBG_BYTE_ADDR_W-1:0] S_DBG_AWADDR,
	input wire S_DBG_WVALID,
	output wire S_DBG_WREADY,
	input wire zip_dbg_pkg::dbg_word_t S_DBG_WDATA,
	input wire zip_dbg_pkg::dbg_strb_t S_DBG_WSTRB,
	output wire S_DBG_BVALID,
	input wire S_DBG_BREADY,
	output wire [1:0] S_DBG_BRESP,
	input wire S_DBG_ARVALID,
	output wire S_DBG_ARREADY,
	input wire [zip_dbg_pkg::DBG_BYTE_ADDR_W-1:0] S_DBG_ARADDR,
	output wire S_DBG_RVALID,
	input wire S_DBG_RREADY,
	output zip_dbg_pkg::dbg_word_t S_DBG_RDATA,
	output wire [1:0] S_DBG_RRESP,
	// Core debug port
	output wire o_cpu_reset,
	output wire o_cpu_halt,
	output wire o_cpu_clear_cache,
	output wire o_cpu_dbg_we,
	output zip_dbg_pkg::reg_index_t o_cpu_dbg_wreg,
	output zip_dbg_pkg::dbg_word_t o_cpu_dbg_wdata,
	output zip_dbg_pkg::reg_index_t o_cpu_dbg_rreg,
	input wire i_cpu_dbg_stall,
	input wire zip_dbg_pkg::dbg_word_t i_cpu_dbg_data,
	input wire zip_dbg_pkg::dbg_cc_t i_cpu_dbg_cc,
	input wire i_cpu_break,
	input wire i_interrupt,
	input wire i_cpu_reset
);

	import zip_dbg_pkg::*;

	// Skid buffer outputs
	wire aw_valid, w_valid, ar_valid;
	dbg_waddr_t aw_addr, ar_addr;
	dbg_word_t w_data;
	dbg_strb_t w_strb;
	// Decoded requests
	wire write_ready, read_ready;
	wire cmd_write, cpu_write, read_cpu;
	dbg_word_t cmd_data, cpu_wdata, status;
	dbg_strb_t cmd_strb;
	reg_index_t cpu_wreg;
	// Back-pressure
	wire write_stall, b_busy, r_busy;

	////////////////////
	// Request channels
	////////////////////

	dbg_skid_buffer #(
		.DW($bits(dbg_waddr_t))
	) aw_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_AWVALID), .o_ready(S_DBG_AWREADY),
		.i_data(S_DBG_AWADDR[DBG_BYTE_ADDR_W-1:DBG_LSB]),
		.o_valid(aw_valid), .i_ready(write_ready), .o_data(aw_addr)
	);

	// Strobes ride above the data
	dbg_skid_buffer #(
		.DW($bits(dbg_word_t) + $bits(dbg_strb_t))
	) w_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_WVALID), .o_ready(S_DBG_WREADY),
		.i_data({S_DBG_WSTRB, S_DBG_WDATA}),
		.o_valid(w_valid), .i_ready(write_ready), .o_data({w_strb, w_data})
	);

	dbg_skid_buffer #(
		.DW($bits(dbg_waddr_t))
	) ar_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_ARVALID), .o_ready(S_DBG_ARREADY),
		.i_data(S_DBG_ARADDR[DBG_BYTE_ADDR_W-1:DBG_LSB]),
		.o_valid(ar_valid), .i_ready(read_ready), .o_data(ar_addr)
	);

	dbg_request_decode decode (
		.i_aw_valid(aw_valid), .i_aw_addr(aw_addr),
		.i_w_valid(w_valid), .i_w_data(w_data), .i_w_strb(w_strb),
		.i_ar_valid(ar_valid), .i_ar_addr(ar_addr),
		.i_write_stall(write_stall), .i_b_busy(b_busy), .i_r_busy(r_busy),
		.o_write_ready(write_ready), .o_read_ready(read_ready),
		.o_cmd_write(cmd_write), .o_cmd_data(cmd_data), .o_cmd_strb(cmd_strb),
		.o_cpu_write(cpu_write), .o_cpu_wreg(cpu_wreg), .o_cpu_wdata(cpu_wdata),
		.o_read_cpu(read_cpu), .o_rreg(o_cpu_dbg_rreg)
	);

	////////////////////
	// Control and response
	////////////////////

	cpu_command_ctrl #(
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(START_HALTED)
	) ctrl (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cmd_write(cmd_write), .i_cmd_data(cmd_data), .i_cmd_strb(cmd_strb),
		.i_cpu_write(cpu_write), .i_cpu_wreg(cpu_wreg), .i_cpu_wdata(cpu_wdata),
		.i_cpu_reset_in(i_cpu_reset), .i_cpu_dbg_stall(i_cpu_dbg_stall),
		.i_cpu_break(i_cpu_break), .i_cpu_dbg_cc(i_cpu_dbg_cc),
		.i_interrupt(i_interrupt),
		.o_cpu_reset(o_cpu_reset), .o_cpu_halt(o_cpu_halt),
		.o_cpu_clear_cache(o_cpu_clear_cache), .o_cpu_dbg_we(o_cpu_dbg_we),
		.o_cpu_dbg_wreg(o_cpu_dbg_wreg), .o_cpu_dbg_wdata(o_cpu_dbg_wdata),
		.o_write_stall(write_stall), .o_status(status)
	);

	dbg_response resp (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_write_accept(write_ready), .i_read_accept(read_ready),
		.i_read_cpu(read_cpu), .i_status(status), .i_cpu_dbg_data(i_cpu_dbg_data),
		.S_DBG_BVALID(S_DBG_BVALID), .S_DBG_BREADY(S_DBG_BREADY),
		.S_DBG_BRESP(S_DBG_BRESP),
		.S_DBG_RVALID(S_DBG_RVALID), .S_DBG_RREADY(S_DBG_RREADY),
		.S_DBG_RDATA(S_DBG_RDATA), .S_DBG_RRESP(S_DBG_RRESP),
		.o_b_busy(b_busy), .o_r_busy(r_busy)
	);

endmodule

`default_nettype wire

/* verilog.f */
common/zip_dbg_pkg.sv
source/dbg_skid_buffer.sv
source/dbg_request_decode.sv
source/cpu_command_ctrl.sv
source/dbg_response.sv
source/zip_dbg_top.sv
dv/zip_dbg_checker.sv
dv/tb_zip_dbg.sv
